//--- verilog/mem_sys_pkg.sv
package mem_sys_pkg;

  // ----------------------------------------------------------------------
  // bus geometry
  // ----------------------------------------------------------------------
  localparam int ADDR_W     = 32;            // byte address
  localparam int DATA_W     = 32;            // one word per beat
  localparam int STRB_W     = DATA_W / 8;    // one enable per byte
  localparam int RAM_ADDR_W = 12;            // 4096 words in the RAM
  localparam int REGION_LSB = 20;            // region field is addr[21:20]

  // ----------------------------------------------------------------------
  // exit block offsets and magic values
  // ----------------------------------------------------------------------
  localparam logic [7:0] EXIT_STATUS_OFS = 8'h00;  // test status word
  localparam logic [7:0] EXIT_CODE_OFS   = 8'h04;  // exit with written value
  localparam logic [7:0] EXIT_ZERO_OFS   = 8'h10;  // exit with zero

  localparam logic [DATA_W-1:0] PASS_MAGIC = 32'd123456789;  // status value for pass
  localparam logic [DATA_W-1:0] FAIL_CODE  = 32'd1;          // status value for fail

  // targets on the load/store side
  typedef enum logic [1:0] {
    REGION_RAM   = 2'd0,  // RAM port B
    REGION_PRINT = 2'd1,  // byte sink
    REGION_EXIT  = 2'd2,  // exit and test status
    REGION_NONE  = 2'd3   // unmapped, error response
  } mem_region_e;

endpackage

//--- verilog/mem_access_if.sv
`timescale 1ns/100ps

// one word access, sampled by the slave on the clock edge where en is high
interface mem_access_if;
  import mem_sys_pkg::*;

  logic              en;     // access strobe
  logic [STRB_W-1:0] we;     // byte write enables, zero for a read
  logic [ADDR_W-1:0] addr;   // byte address
  logic [DATA_W-1:0] wdata;  // write data
  logic [DATA_W-1:0] rdata;  // valid the cycle after en, held until next en

  modport master (
    output en, we, addr, wdata,
    input  rdata
  );

  modport slave (
    input  en, we, addr, wdata,
    output rdata
  );

endinterface

//--- verilog/bus_port_ctrl.sv
`timescale 1ns/100ps

// single-beat valid/ready port, one response in flight
module bus_port_ctrl (
  input  logic                            clk_i,
  input  logic                            rst_i,
  // request channel
  input  logic                            req_valid_i,
  output logic                            req_ready_o,
  input  logic [mem_sys_pkg::ADDR_W-1:0]  addr_i,
  input  logic                            we_i,
  input  logic [mem_sys_pkg::STRB_W-1:0]  wstrb_i,
  input  logic [mem_sys_pkg::DATA_W-1:0]  wdata_i,
  // response channel
  output logic                            rsp_valid_o,
  input  logic                            rsp_ready_i,
  output logic [mem_sys_pkg::DATA_W-1:0]  rdata_o,
  // word access toward the target
  mem_access_if.master                    acc
);

  logic accept;       // request transfers this cycle
  logic rsp_valid_q;  // response held for the requester
  logic write_q;      // held response belongs to a write

  // ----------------------------------------------------------------------
  // request side
  // ----------------------------------------------------------------------
  assign req_ready_o = ~rsp_valid_q | rsp_ready_i;  // free slot or slot emptied now
  assign accept      = req_valid_i & req_ready_o;

  assign acc.en    = accept;                   // target samples on this edge
  assign acc.we    = we_i ? wstrb_i : '0;      // strobes only count for writes
  assign acc.addr  = addr_i;
  assign acc.wdata = wdata_i;

  // ----------------------------------------------------------------------
  // response side
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rsp_valid_q <= 1'b0;
      write_q     <= 1'b0;
    end else if (accept) begin
      rsp_valid_q <= 1'b1;              // data arrives one cycle later
      write_q     <= we_i;
    end else if (rsp_ready_i) begin
      rsp_valid_q <= 1'b0;              // taken, slot free again
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  // target holds rdata until the next en, so no capture register is needed
  assign rdata_o     = write_q ? '0 : acc.rdata;

  // a stalled response keeps valid and data
  a_rsp_hold : assert property (@(posedge clk_i) disable iff (rst_i)
    (rsp_valid_o && !rsp_ready_i) |=> (rsp_valid_o && $stable(rdata_o)))
    else $error("response dropped or changed under back-pressure");

endmodule

//--- verilog/dp_byte_ram.sv
`timescale 1ns/100ps

// true dual-port word RAM, byte writes, registered read-first output
module dp_byte_ram (
  input  logic         clk_i,
  mem_access_if.slave  port_a,   // fetch side
  mem_access_if.slave  port_b    // load/store side
);
  import mem_sys_pkg::*;

  localparam int DEPTH = 2 ** RAM_ADDR_W;

  logic [DATA_W-1:0]     mem [DEPTH];   // storage
  logic [RAM_ADDR_W-1:0] idx_a;         // word index, port A
  logic [RAM_ADDR_W-1:0] idx_b;         // word index, port B
  logic [DATA_W-1:0]     rdata_a_q;     // port A read register
  logic [DATA_W-1:0]     rdata_b_q;     // port B read register

  assign idx_a = port_a.addr[RAM_ADDR_W+1:2];  // drop byte offset, alias above 16 KB
  assign idx_b = port_b.addr[RAM_ADDR_W+1:2];

  // one process for both ports so a same-word collision resolves in order
  always_ff @(posedge clk_i) begin
    if (port_a.en) begin
      rdata_a_q <= mem[idx_a];          // old contents, read-first
    end
    if (port_b.en) begin
      rdata_b_q <= mem[idx_b];
    end
    for (int i = 0; i < STRB_W; i++) begin
      if (port_a.en && port_a.we[i]) begin
        mem[idx_a][i*8 +: 8] <= port_a.wdata[i*8 +: 8];
      end
      if (port_b.en && port_b.we[i]) begin
        mem[idx_b][i*8 +: 8] <= port_b.wdata[i*8 +: 8];  // later update, port B wins
      end
    end
  end

  assign port_a.rdata = rdata_a_q;     // holds while en is low
  assign port_b.rdata = rdata_b_q;

  a_addr_a_known : assert property (@(posedge clk_i)
    port_a.en |-> !$isunknown(port_a.addr))
    else $error("port A access with unknown address");

  a_addr_b_known : assert property (@(posedge clk_i)
    port_b.en |-> !$isunknown(port_b.addr))
    else $error("port B access with unknown address");

endmodule

//--- verilog/data_region_decoder.sv
`timescale 1ns/100ps

// steers load/store accesses to RAM, host I/O or nowhere
module data_region_decoder (
  input  logic          clk_i,
  input  logic          rst_i,
  mem_access_if.slave   upstream,   // from the load/store port
  mem_access_if.master  ram_side,   // RAM port B
  mem_access_if.master  io_side,    // print and exit block
  output logic          err_o       // response belongs to an unmapped access
);
  import mem_sys_pkg::*;

  mem_region_e region;     // target of the current access
  mem_region_e region_q;   // target of the access being answered
  logic        is_io;      // print or exit

  // ----------------------------------------------------------------------
  // decode and forward
  // ----------------------------------------------------------------------
  assign region = mem_region_e'(upstream.addr[REGION_LSB +: 2]);
  assign is_io  = (region == REGION_PRINT) || (region == REGION_EXIT);

  assign ram_side.en    = upstream.en && (region == REGION_RAM);
  assign ram_side.we    = upstream.we;
  assign ram_side.addr  = upstream.addr;
  assign ram_side.wdata = upstream.wdata;

  assign io_side.en     = upstream.en && is_io;
  assign io_side.we     = upstream.we;
  assign io_side.addr   = upstream.addr;   // host I/O needs region and offset
  assign io_side.wdata  = upstream.wdata;

  // ----------------------------------------------------------------------
  // return path
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      region_q <= REGION_RAM;              // no error after reset
    end else if (upstream.en) begin
      region_q <= region;                  // held until the next access
    end
  end

  always_comb begin
    case (region_q)
      REGION_RAM:   upstream.rdata = ram_side.rdata;
      REGION_PRINT,
      REGION_EXIT:  upstream.rdata = io_side.rdata;   // host I/O reads as zero
      default:      upstream.rdata = '0;              // unmapped
    endcase
  end

  assign err_o = (region_q == REGION_NONE);

  // host I/O answers every access with zero data
  a_io_rdata_zero : assert property (@(posedge clk_i) disable iff (rst_i)
    ((region_q == REGION_PRINT) || (region_q == REGION_EXIT)) |-> (io_side.rdata == '0))
    else $error("host I/O response returned nonzero data");

endmodule

//--- verilog/host_io_regs.sv
`timescale 1ns/100ps

// print byte sink and exit/test-status block
module host_io_regs (
  input  logic                           clk_i,
  input  logic                           rst_i,
  mem_access_if.slave                    bus,
  output logic                           print_valid_o,
  output logic [7:0]                     print_data_o,
  output logic                           tests_passed_o,
  output logic                           tests_failed_o,
  output logic                           exit_valid_o,
  output logic [mem_sys_pkg::DATA_W-1:0] exit_value_o
);
  import mem_sys_pkg::*;

  mem_region_e region;    // print or exit, from the address
  logic [7:0]  ofs;       // offset inside the exit block
  logic        wr;        // write with at least one byte enabled

  assign region = mem_region_e'(bus.addr[REGION_LSB +: 2]);
  assign ofs    = bus.addr[7:0];
  assign wr     = bus.en && (|bus.we);

  // ----------------------------------------------------------------------
  // pulse flags, high for the cycle after the write edge
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      print_valid_o  <= 1'b0;
      tests_passed_o <= 1'b0;
      tests_failed_o <= 1'b0;
      exit_valid_o   <= 1'b0;
    end else begin
      print_valid_o  <= wr && (region == REGION_PRINT);
      tests_passed_o <= wr && (region == REGION_EXIT) && (ofs == EXIT_STATUS_OFS)
                        && (bus.wdata == PASS_MAGIC);
      tests_failed_o <= wr && (region == REGION_EXIT) && (ofs == EXIT_STATUS_OFS)
                        && (bus.wdata == FAIL_CODE);
      exit_valid_o   <= wr && (region == REGION_EXIT)
                        && ((ofs == EXIT_CODE_OFS) || (ofs == EXIT_ZERO_OFS));
    end
  end

  // ----------------------------------------------------------------------
  // payload, loaded with the matching pulse
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (wr && (region == REGION_PRINT)) begin
      print_data_o <= bus.wdata[7:0];      // low byte only
    end
    if (wr && (region == REGION_EXIT)) begin
      if (ofs == EXIT_CODE_OFS) begin
        exit_value_o <= bus.wdata;
      end else if (ofs == EXIT_ZERO_OFS) begin
        exit_value_o <= '0;
      end
    end
  end

  assign bus.rdata = '0;                   // write-only block

endmodule

//--- verilog/mem_sys_top.sv
`timescale 1ns/100ps

// memory side of the test harness: fetch port, load/store port, RAM, host I/O
module mem_sys_top (
  input  logic                           clk_i,
  input  logic                           rst_i,
  // fetch port
  input  logic                           fetch_req_valid_i,
  output logic                           fetch_req_ready_o,
  input  logic [mem_sys_pkg::ADDR_W-1:0] fetch_addr_i,
  input  logic                           fetch_we_i,
  input  logic [mem_sys_pkg::STRB_W-1:0] fetch_wstrb_i,
  input  logic [mem_sys_pkg::DATA_W-1:0] fetch_wdata_i,
  output logic                           fetch_rsp_valid_o,
  input  logic                           fetch_rsp_ready_i,
  output logic [mem_sys_pkg::DATA_W-1:0] fetch_rdata_o,
  // load/store port
  input  logic                           ls_req_valid_i,
  output logic                           ls_req_ready_o,
  input  logic [mem_sys_pkg::ADDR_W-1:0] ls_addr_i,
  input  logic                           ls_we_i,
  input  logic [mem_sys_pkg::STRB_W-1:0] ls_wstrb_i,
  input  logic [mem_sys_pkg::DATA_W-1:0] ls_wdata_i,
  output logic                           ls_rsp_valid_o,
  input  logic                           ls_rsp_ready_i,
  output logic [mem_sys_pkg::DATA_W-1:0] ls_rdata_o,
  output logic                           ls_rsp_err_o,
  // host outputs
  output logic                           print_valid_o,
  output logic [7:0]                     print_data_o,
  output logic                           tests_passed_o,
  output logic                           tests_failed_o,
  output logic                           exit_valid_o,
  output logic [mem_sys_pkg::DATA_W-1:0] exit_value_o
);

  mem_access_if fetch_acc ();   // fetch port to RAM port A
  mem_access_if ls_acc ();      // load/store port to decoder
  mem_access_if ram_b_acc ();   // decoder to RAM port B
  mem_access_if io_acc ();      // decoder to host I/O

  // ----------------------------------------------------------------------
  // port controllers
  // ----------------------------------------------------------------------
  bus_port_ctrl fetch_port (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_valid_i (fetch_req_valid_i),
    .req_ready_o (fetch_req_ready_o),
    .addr_i      (fetch_addr_i),
    .we_i        (fetch_we_i),
    .wstrb_i     (fetch_wstrb_i),
    .wdata_i     (fetch_wdata_i),
    .rsp_valid_o (fetch_rsp_valid_o),
    .rsp_ready_i (fetch_rsp_ready_i),
    .rdata_o     (fetch_rdata_o),
    .acc         (fetch_acc.master)
  );

  bus_port_ctrl ls_port (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_valid_i (ls_req_valid_i),
    .req_ready_o (ls_req_ready_o),
    .addr_i      (ls_addr_i),
    .we_i        (ls_we_i),
    .wstrb_i     (ls_wstrb_i),
    .wdata_i     (ls_wdata_i),
    .rsp_valid_o (ls_rsp_valid_o),
    .rsp_ready_i (ls_rsp_ready_i),
    .rdata_o     (ls_rdata_o),
    .acc         (ls_acc.master)
  );

  // ----------------------------------------------------------------------
  // targets
  // ----------------------------------------------------------------------
  data_region_decoder u_decoder (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .upstream (ls_acc.slave),
    .ram_side (ram_b_acc.master),
    .io_side  (io_acc.master),
    .err_o    (ls_rsp_err_o)        // meaningful with ls_rsp_valid_o
  );

  dp_byte_ram u_ram (
    .clk_i  (clk_i),
    .port_a (fetch_acc.slave),
    .port_b (ram_b_acc.slave)
  );

  host_io_regs u_host_io (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .bus            (io_acc.slave),
    .print_valid_o  (print_valid_o),
    .print_data_o   (print_data_o),
    .tests_passed_o (tests_passed_o),
    .tests_failed_o (tests_failed_o),
    .exit_valid_o   (exit_valid_o),
    .exit_value_o   (exit_value_o)
  );

endmodule

//--- test/mem_sys_checker.sv
`timescale 1ns/100ps

// scoreboard for both request ports, RAM image and host outputs
module mem_sys_checker (
  input  logic        clk_i,
  input  logic        rst_i,
  // fetch port as seen at the DUT pins
  input  logic        f_req_valid_i, f_req_ready_i, f_we_i, f_rsp_valid_i, f_rsp_ready_i,
  input  logic [31:0] f_addr_i, f_wdata_i, f_rdata_i,
  input  logic [3:0]  f_wstrb_i,
  // load/store port
  input  logic        l_req_valid_i, l_req_ready_i, l_we_i, l_rsp_valid_i, l_rsp_ready_i,
  input  logic        l_err_i,
  input  logic [31:0] l_addr_i, l_wdata_i, l_rdata_i,
  input  logic [3:0]  l_wstrb_i,
  // host outputs
  input  logic        print_valid_i, passed_i, failed_i, exit_valid_i,
  input  logic [7:0]  print_data_i,
  input  logic [31:0] exit_value_i,
  output int          mismatches_o,
  output int          proto_errors_o,
  output int          pending_o        // responses still owed
);
  import mem_sys_pkg::*;

  logic [31:0] model [4096];    // word image of the RAM
  logic        exp_vld [2];     // response owed, 0 = fetch, 1 = ls
  logic [31:0] exp_rdata [2];
  logic        exp_err [2];
  logic        acc_d [2];       // accepted at the previous edge
  logic        hold [2];        // stalled at the previous edge
  logic [31:0] hold_data [2];
  logic        rst_d;           // reset seen at the previous edge
  logic        exp_print_v, exp_pass, exp_fail, exp_exit_v;  // pulses due this edge
  logic [7:0]  exp_print_d;
  logic [31:0] exp_exit_val;

  assign pending_o = int'(exp_vld[0]) + int'(exp_vld[1]);

  task automatic report_mismatch(input string msg);
    $display("mismatch at %0t: %s", $time, msg);
    mismatches_o++;
  endtask

  task automatic report_protocol(input string msg);
    $display("protocol error at %0t: %s", $time, msg);
    proto_errors_o++;
  endtask

  task automatic write_model(input logic [31:0] addr, input logic [3:0] strb,
                             input logic [31:0] data);
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) model[addr[13:2]][i*8 +: 8] = data[i*8 +: 8];  // byte lanes
    end
  endtask

  // ----------------------------------------------------------------------
  // response channel rules for one port
  // ----------------------------------------------------------------------
  task automatic check_rsp(input int p, input string name, input logic rsp_valid,
                           input logic rsp_ready, input logic req_ready,
                           input logic [31:0] rdata, input logic err);
    if (acc_d[p] && !rsp_valid)
      report_protocol({name, " response did not follow one cycle after acceptance"});
    if (hold[p] && (!rsp_valid || rdata !== hold_data[p]))
      report_protocol({name, " stalled response was dropped or its data changed"});
    if (req_ready !== (!rsp_valid || rsp_ready))
      report_protocol({name, " request ready does not match the response state"});
    if (rsp_valid && rsp_ready) begin
      if (!exp_vld[p]) begin
        report_protocol({name, " response with no request in flight"});
      end else if (rdata !== exp_rdata[p] || err !== exp_err[p]) begin
        report_mismatch($sformatf("%s rdata/err got %h/%b expected %h/%b", name,
                                  rdata, err, exp_rdata[p], exp_err[p]));
      end
      exp_vld[p] = 1'b0;                 // taken
    end
    hold[p]      = rsp_valid && !rsp_ready;
    hold_data[p] = rdata;
  endtask

  // host pulses are due in the response cycle of the write
  task automatic check_host();
    if (print_valid_i !== exp_print_v || (exp_print_v && print_data_i !== exp_print_d))
      report_mismatch($sformatf("print got %b/%h expected %b/%h", print_valid_i,
                                print_data_i, exp_print_v, exp_print_d));
    if (passed_i !== exp_pass || failed_i !== exp_fail)
      report_mismatch($sformatf("pass/fail got %b%b expected %b%b", passed_i, failed_i,
                                exp_pass, exp_fail));
    if (exit_valid_i !== exp_exit_v || (exp_exit_v && exit_value_i !== exp_exit_val))
      report_mismatch($sformatf("exit got %b/%h expected %b/%h", exit_valid_i,
                                exit_value_i, exp_exit_v, exp_exit_val));
    exp_print_v = 1'b0;
    exp_pass    = 1'b0;
    exp_fail    = 1'b0;
    exp_exit_v  = 1'b0;
  endtask

  // ----------------------------------------------------------------------
  // per-edge sampling, values seen here are the pre-edge ones
  // ----------------------------------------------------------------------
  always @(posedge clk_i) begin
    logic        f_acc;
    logic        l_acc;
    mem_region_e l_reg;
    logic [7:0]  ofs;
    f_acc = f_req_valid_i && f_req_ready_i;
    l_acc = l_req_valid_i && l_req_ready_i;
    l_reg = mem_region_e'(l_addr_i[21:20]);
    ofs   = l_addr_i[7:0];
    if (rst_i) begin
      mismatches_o   = 0;
      proto_errors_o = 0;
      rst_d          = 1'b1;
      for (int p = 0; p < 2; p++) begin
        exp_vld[p] = 1'b0;
        acc_d[p]   = 1'b0;
        hold[p]    = 1'b0;
      end
      exp_print_v = 1'b0;
      exp_pass    = 1'b0;
      exp_fail    = 1'b0;
      exp_exit_v  = 1'b0;
    end else begin
      // first cycle out of reset: ready high, valids and pulses low
      if (rst_d && {f_req_ready_i, l_req_ready_i, f_rsp_valid_i, l_rsp_valid_i,
                    print_valid_i, passed_i, failed_i, exit_valid_i} !== 8'b1100_0000)
        report_protocol("outputs not in their reset state after reset");
      rst_d = 1'b0;
      check_rsp(0, "fetch", f_rsp_valid_i, f_rsp_ready_i, f_req_ready_i, f_rdata_i, 1'b0);
      check_rsp(1, "ls", l_rsp_valid_i, l_rsp_ready_i, l_req_ready_i, l_rdata_i, l_err_i);
      check_host();
      if (f_acc) begin
        exp_vld[0]   = 1'b1;
        exp_err[0]   = 1'b0;
        exp_rdata[0] = f_we_i ? '0 : model[f_addr_i[13:2]];  // read-first
      end
      if (l_acc) begin
        exp_vld[1]   = 1'b1;
        exp_err[1]   = (l_reg == REGION_NONE);
        exp_rdata[1] = (l_we_i || l_reg != REGION_RAM) ? '0 : model[l_addr_i[13:2]];
        if (l_we_i && (|l_wstrb_i) && l_reg == REGION_PRINT) begin
          exp_print_v = 1'b1;
          exp_print_d = l_wdata_i[7:0];
        end
        if (l_we_i && (|l_wstrb_i) && l_reg == REGION_EXIT) begin
          exp_pass     = (ofs == 8'h00) && (l_wdata_i == 32'd123456789);
          exp_fail     = (ofs == 8'h00) && (l_wdata_i == 32'd1);
          exp_exit_v   = (ofs == 8'h04) || (ofs == 8'h10);
          exp_exit_val = (ofs == 8'h04) ? l_wdata_i : '0;
        end
      end
      if (f_acc && f_we_i) write_model(f_addr_i, f_wstrb_i, f_wdata_i);
      if (l_acc && l_we_i && l_reg == REGION_RAM)
        write_model(l_addr_i, l_wstrb_i, l_wdata_i);  // applied last, port B wins
      acc_d[0] = f_acc;
      acc_d[1] = l_acc;
    end
  end

endmodule

//--- test/tb_mem_sys.sv
`timescale 1ns/100ps

module tb_mem_sys;

  localparam int N_TXN      = 3000;   // random requests per port
  localparam int N_PRELOAD  = 64;     // words written before random traffic
  localparam int RST_CYCLES = 16;
  localparam int LIMIT_NS   = (N_PRELOAD + N_TXN) * 20 * 8 + RST_CYCLES * 8;

  logic        clk_i = 1'b0;
  logic        rst_i;
  logic        fetch_req_valid_i, fetch_we_i, fetch_rsp_ready_i;
  logic        fetch_req_ready_o, fetch_rsp_valid_o;
  logic [31:0] fetch_addr_i, fetch_wdata_i, fetch_rdata_o;
  logic [3:0]  fetch_wstrb_i;
  logic        ls_req_valid_i, ls_we_i, ls_rsp_ready_i;
  logic        ls_req_ready_o, ls_rsp_valid_o, ls_rsp_err_o;
  logic [31:0] ls_addr_i, ls_wdata_i, ls_rdata_o;
  logic [3:0]  ls_wstrb_i;
  logic        print_valid_o, tests_passed_o, tests_failed_o, exit_valid_o;
  logic [7:0]  print_data_o;
  logic [31:0] exit_value_o;
  int          mismatches, proto_errors, pending;
  int          f_done, l_done;        // accepted requests
  logic [31:0] a, d;
  logic        w;
  logic [3:0]  s;

  always #4 clk_i = ~clk_i;           // 8 ns period

  mem_sys_top dut0 (.*);

  mem_sys_checker chk0 (
    .clk_i (clk_i), .rst_i (rst_i),
    .f_req_valid_i (fetch_req_valid_i), .f_req_ready_i (fetch_req_ready_o),
    .f_we_i (fetch_we_i), .f_rsp_valid_i (fetch_rsp_valid_o),
    .f_rsp_ready_i (fetch_rsp_ready_i), .f_addr_i (fetch_addr_i),
    .f_wdata_i (fetch_wdata_i), .f_rdata_i (fetch_rdata_o), .f_wstrb_i (fetch_wstrb_i),
    .l_req_valid_i (ls_req_valid_i), .l_req_ready_i (ls_req_ready_o), .l_we_i (ls_we_i),
    .l_rsp_valid_i (ls_rsp_valid_o), .l_rsp_ready_i (ls_rsp_ready_i),
    .l_err_i (ls_rsp_err_o), .l_addr_i (ls_addr_i), .l_wdata_i (ls_wdata_i),
    .l_rdata_i (ls_rdata_o), .l_wstrb_i (ls_wstrb_i),
    .print_valid_i (print_valid_o), .passed_i (tests_passed_o), .failed_i (tests_failed_o),
    .exit_valid_i (exit_valid_o), .print_data_i (print_data_o),
    .exit_value_i (exit_value_o), .mismatches_o (mismatches),
    .proto_errors_o (proto_errors), .pending_o (pending)
  );

  // random request, word index kept in 0..63 with random alias bits above
  task automatic pick_request(input bit to_ls, output logic [31:0] addr, output logic we,
                              output logic [3:0] strb, output logic [31:0] data);
    int         sel;
    logic [1:0] region;
    sel    = $urandom % 8;
    region = to_ls ? ((sel < 5) ? 2'd0 : 2'(sel - 4)) : 2'($urandom);  // ls mostly RAM
    addr   = ($urandom & 32'hFFCF_C000) | (($urandom % 64) << 2) | ($urandom % 4);
    addr[21:20] = region;
    we     = 1'($urandom);
    strb   = 4'($urandom);                         // zero strobe included
    data   = $urandom;
    if (to_ls && region == 2'd2) begin
      sel        = $urandom % 4;
      addr[7:0]  = (sel == 0) ? 8'h00 : (sel == 1) ? 8'h04 : (sel == 2) ? 8'h10 : 8'($urandom);
      if ($urandom % 2 != 0) data = ($urandom % 2 != 0) ? 32'd123456789 : 32'd1;
    end
  endtask

  // ----------------------------------------------------------------------
  // watchdog
  // ----------------------------------------------------------------------
  initial begin
    #(LIMIT_NS);
    $display("timeout: run did not finish within %0d ns", LIMIT_NS);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  // ----------------------------------------------------------------------
  // stimulus
  // ----------------------------------------------------------------------
  initial begin
    void'($urandom(41761));
    f_done    = 0;
    l_done    = 0;
    rst_i     = 1'b1;
    {fetch_req_valid_i, fetch_we_i, fetch_rsp_ready_i, fetch_wstrb_i} = '0;
    {ls_req_valid_i, ls_we_i, ls_rsp_ready_i, ls_wstrb_i} = '0;
    {fetch_addr_i, fetch_wdata_i, ls_addr_i, ls_wdata_i} = '0;
    repeat (RST_CYCLES) @(posedge clk_i);
    rst_i <= 1'b0;
    while (f_done < N_PRELOAD + N_TXN || l_done < N_TXN) begin
      @(posedge clk_i);
      if (fetch_req_valid_i && fetch_req_ready_o) f_done++;
      if (ls_req_valid_i && ls_req_ready_o) l_done++;
      if (!fetch_req_valid_i || fetch_req_ready_o) begin
        if (f_done < N_PRELOAD) begin           // preload full words
          fetch_req_valid_i <= 1'b1;
          fetch_we_i        <= 1'b1;
          fetch_wstrb_i     <= 4'hF;
          fetch_addr_i      <= 32'(f_done << 2);
          fetch_wdata_i     <= $urandom;
        end else if (f_done < N_PRELOAD + N_TXN) begin
          pick_request(1'b0, a, w, s, d);
          fetch_req_valid_i <= ($urandom % 4) != 0;
          {fetch_addr_i, fetch_we_i, fetch_wstrb_i, fetch_wdata_i} <= {a, w, s, d};
        end else begin
          fetch_req_valid_i <= 1'b0;
        end
      end
      if (!ls_req_valid_i || ls_req_ready_o) begin
        pick_request(1'b1, a, w, s, d);
        ls_req_valid_i <= (f_done >= N_PRELOAD) && (l_done < N_TXN) && ($urandom % 4 != 0);
        {ls_addr_i, ls_we_i, ls_wstrb_i, ls_wdata_i} <= {a, w, s, d};
      end
      fetch_rsp_ready_i <= (f_done < N_PRELOAD) || ($urandom % 4 != 0);  // back-pressure
      ls_rsp_ready_i    <= ($urandom % 4) != 0;
    end
    fetch_req_valid_i <= 1'b0;
    ls_req_valid_i    <= 1'b0;
    fetch_rsp_ready_i <= 1'b1;
    ls_rsp_ready_i    <= 1'b1;
    do @(negedge clk_i); while (pending != 0);  // drain owed responses
    repeat (2) @(negedge clk_i);
    $display("errors: %0d mismatch, %0d protocol (%0d fetch, %0d ls requests)",
             mismatches, proto_errors, f_done, l_done);
    if (mismatches == 0 && proto_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- vlog.f
verilog/mem_sys_pkg.sv
verilog/mem_access_if.sv
verilog/bus_port_ctrl.sv
verilog/dp_byte_ram.sv
verilog/data_region_decoder.sv
verilog/host_io_regs.sv
verilog/mem_sys_top.sv
test/mem_sys_checker.sv
test/tb_mem_sys.sv

//--- Makefile
# Verilator flow for the memory system testbench

VERILATOR  ?= verilator
TOP        ?= tb_mem_sys
RTL_TOP    ?= mem_sys_top
FILELIST   ?= vlog.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= -Wall

SRCS := $(shell grep -v '^+' $(FILELIST))
RTL  := $(filter verilog/%,$(SRCS))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL)

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
